// File: common/mipsPkg.sv
// ----------------------------------------------------------
// shared constants and the instruction word for the core
// andi and ori sign-extend their immediate like addi
// opcodes outside the supported subset decode as bubbles
// ----------------------------------------------------------
package mipsPkg;

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int regCount     = 32;

  localparam logic [31:0] pcReset = 32'h0000_3000;

  // ----------------------------------------------------------
  // opcodes and R-type function codes
  // ----------------------------------------------------------
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opAddi  = 6'h08;
  localparam logic [5:0] opAndi  = 6'h0c;
  localparam logic [5:0] opOri   = 6'h0d;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;

  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // bit 3 inverts a, bit 2 inverts b and adds one,
  // bits 1:0 pick or, and, add, slt
  localparam logic [3:0] aluOr  = 4'b0000;
  localparam logic [3:0] aluAnd = 4'b0001;
  localparam logic [3:0] aluAdd = 4'b0010;
  localparam logic [3:0] aluSub = 4'b0110;
  localparam logic [3:0] aluSlt = 4'b0111;

  // operand sources in execute
  localparam logic [1:0] fwdReg = 2'd0;
  localparam logic [1:0] fwdMem = 2'd1;
  localparam logic [1:0] fwdWb  = 2'd2;

  // ----------------------------------------------------------
  // instruction word in its three formats
  // ----------------------------------------------------------
  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFields_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFields_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } jFields_t;

  typedef union packed {
    rFields_t r;
    iFields_t i;
    jFields_t j;
  } instrWord_t;

endpackage

// File: dv/tbPrograms.svh
// ----------------------------------------------------------
// test programs, expected stores and cycle budgets
// each program ends with endMark, stores are addr, data pairs
// programs must leave a gap of one instruction after a lw
// ----------------------------------------------------------
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam logic [31:0] endMark = 32'hffff_ffff;

string testNames [$] = '{"arith", "loadStore", "branch", "jump", "regZero"};

// cycles run after reset release, one per test
int budgets [$] = '{30, 20, 22, 22, 20};

logic [31:0] progStream [$] = '{
  // addi r1,r0,5; addi r2,r1,-12; add r3,r1,r2; sub r4,r3,r1
  32'h2001_0005, 32'h2022_fff4, 32'h0022_1820, 32'h0061_2022,
  // and r5,r4,r3; or r6,r5,r1; slt r7,r2,r1; slt r8,r1,r6
  32'h0083_2824, 32'h00a1_3025, 32'h0041_382a, 32'h0026_402a,
  // andi r9,r6,0xf0; ori r10,r9,3; then sw r2..r8, r10 to 0x00..0x1c
  32'h30c9_00f0, 32'h352a_0003, 32'hac02_0000, 32'hac03_0004,
  32'hac04_0008, 32'hac05_000c, 32'hac06_0010, 32'hac07_0014,
  32'hac08_0018, 32'hac0a_001c, endMark,
  // addi r1,r0,0x40; addi r2,r0,0x1234; sw r2,4(r1); lw r3,4(r1)
  32'h2001_0040, 32'h2002_1234, 32'hac22_0004, 32'h8c23_0004,
  // addi r4,r0,8; add r5,r3,r4; sw r5,-4(r1); sw r3,0x10(r1)
  32'h2004_0008, 32'h0064_2820, 32'hac25_fffc, 32'hac23_0010, endMark,
  // addi r1,r0,3; addi r2,r0,3; beq r1,r2,+4; three squashed sw
  32'h2001_0003, 32'h2002_0003, 32'h1022_0004, 32'hac01_0000,
  // squashed sw; skipped sw; target sw r2,0x20; beq r1,r0 not taken
  32'hac01_0004, 32'hac01_0008, 32'hac01_000c, 32'hac02_0020,
  32'h1020_0002, 32'hac01_0024, 32'hac02_0028, endMark,
  // addi r1,r0,0x77; j 0x3020; three squashed and three skipped sw
  32'h2001_0077, 32'h0800_0c08, 32'hac01_0000, 32'hac01_0004,
  32'hac01_0008, 32'hac01_000c, 32'hac01_0010, 32'hac01_0014,
  // target: sw r1,0x30; addi r2,r1,1; sw r2,0x34
  32'hac01_0030, 32'h2022_0001, 32'hac02_0034, endMark,
  // addi r0,r0,0x55; sw r0,0; sw r0,4; addi r3,r0,0x99
  32'h2000_0055, 32'hac00_0000, 32'hac00_0004, 32'h2003_0099,
  // addi r4,r0,1; addi r5,r0,2; sw r3,8 reads in WB cycle; sw r0,12
  32'h2004_0001, 32'h2005_0002, 32'hac03_0008, 32'hac00_000c, endMark
};

logic [31:0] storeStream [$] = '{
  32'h00, 32'hffff_fff9, 32'h04, 32'hffff_fffe, 32'h08, 32'hffff_fff9,
  32'h0c, 32'hffff_fff8, 32'h10, 32'hffff_fffd, 32'h14, 32'h0000_0001,
  32'h18, 32'h0000_0000, 32'h1c, 32'h0000_00f3, endMark,
  32'h44, 32'h0000_1234, 32'h3c, 32'h0000_123c, 32'h50, 32'h0000_1234, endMark,
  32'h20, 32'h0000_0003, 32'h24, 32'h0000_0003, 32'h28, 32'h0000_0003, endMark,
  32'h30, 32'h0000_0077, 32'h34, 32'h0000_0078, endMark,
  32'h00, 32'h0000_0000, 32'h04, 32'h0000_0000, 32'h08, 32'h0000_0099,
  32'h0c, 32'h0000_0000, endMark
};

`endif

// File: dv/mipsCoreTb.sv
// ----------------------------------------------------------
// testbench for the pipelined core
// both memories answer combinationally, data memory is 64 words
// stores are checked in order against the program table
// ----------------------------------------------------------
`timescale 1ns/1ps

module mipsCoreTb;

  localparam int resetCycles = 16;
  localparam int progWords   = 24;
  localparam int dmemWords   = 64;

  `include "tbPrograms.svh"

  logic        clk;
  logic        rst;
  logic [31:0] instrData;
  logic [31:0] pc;
  logic [31:0] memAddr;
  logic [31:0] memWriteData;
  logic        memWrite;
  logic        memRead;
  logic [31:0] memReadData;

  logic [31:0] rom  [progWords];
  logic [31:0] dmem [dmemWords];
  logic [31:0] romOffset;
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  int          errors;
  int          checks;
  int          cycleCount;
  int          cycleLimit;

  mipsCore i_mipsCore (
    .clk          (clk),
    .rst          (rst),
    .instrData    (instrData),
    .pc           (pc),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memWrite     (memWrite),
    .memRead      (memRead),
    .memReadData  (memReadData)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // memory models
  // ----------------------------------------------------------
  assign romOffset   = pc - mipsPkg::pcReset;
  assign instrData   = (romOffset[31:2] < progWords) ? rom[romOffset[6:2]] : '0;
  // data only while the core reads
  assign memReadData = memRead ? dmem[memAddr[7:2]] : '0;

  task automatic checkStore();
    logic [31:0] addr;
    logic [31:0] data;
    checks++;
    assert (expAddr.size() > 0)
    else
    begin
      $display("unexpected store of %h to %h at %0t", memWriteData, memAddr, $time);
      errors++;
    end
    if (expAddr.size() > 0)
    begin
      addr = expAddr.pop_front();
      data = expData.pop_front();
      assert (memAddr == addr)
      else
      begin
        $display("Mismatch at %0t: memAddr is %h, expected %h", $time, memAddr, addr);
        errors++;
      end
      assert (memWriteData == data)
      else
      begin
        $display("Mismatch at %0t: memWriteData is %h, expected %h", $time, memWriteData, data);
        errors++;
      end
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst && memWrite)
    begin
      dmem[memAddr[7:2]] <= memWriteData;
      checkStore();
    end
  end

  // strobes are looked at mid-cycle while reset holds
  always @(negedge clk)
  begin
    if (rst)
    begin
      checks++;
      assert (memWrite == 1'b0)
      else
      begin
        $display("Mismatch at %0t: memWrite is %b during reset, expected 0", $time, memWrite);
        errors++;
      end
      assert (memRead == 1'b0)
      else
      begin
        $display("Mismatch at %0t: memRead is %b during reset, expected 0", $time, memRead);
        errors++;
      end
    end
  end

  // run limit
  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
    begin
      $display("run stopped after %0d cycles without finishing", cycleCount);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // table loading
  // ----------------------------------------------------------
  task automatic loadProgram(inout int pos);
    int n;
    n = 0;
    foreach (rom[i])
      rom[i] = '0;
    while (progStream[pos] != endMark)
    begin
      if (n < progWords)
        rom[n] = progStream[pos];
      n++;
      pos++;
    end
    pos++;
    assert (n <= progWords)
    else
    begin
      $display("program of %0d words does not fit the ROM", n);
      errors++;
    end
  endtask

  task automatic loadStores(inout int pos);
    expAddr.delete();
    expData.delete();
    while (storeStream[pos] != endMark)
    begin
      expAddr.push_back(storeStream[pos]);
      expData.push_back(storeStream[pos + 1]);
      pos += 2;
    end
    pos++;
  endtask

  // ----------------------------------------------------------
  // test loop
  // ----------------------------------------------------------
  initial
  begin
    int progPos;
    int storePos;
    int testErrors;
    int t;
    int k;
    rst        = 1'b1;
    errors     = 0;
    checks     = 0;
    cycleCount = 0;
    progPos    = 0;
    storePos   = 0;
    foreach (rom[i])
      rom[i] = '0;
    foreach (dmem[i])
      dmem[i] = '0;
    cycleLimit = budgets.size() * resetCycles + 50;
    foreach (budgets[i])
      cycleLimit += budgets[i];

    for (t = 0; t < budgets.size(); t++)
    begin
      @(posedge clk);
      rst <= 1'b1;
      @(posedge clk);
      testErrors = errors;
      loadProgram(progPos);
      loadStores(storePos);
      foreach (dmem[i])
        dmem[i] = '0;
      repeat (resetCycles - 1) @(posedge clk);
      rst <= 1'b0;

      // pc runs sequentially before any branch can take effect
      for (k = 0; k < 4; k++)
      begin
        @(posedge clk);
        checks++;
        assert (pc == mipsPkg::pcReset + 32'(4 * k))
        else
        begin
          $display("Mismatch at %0t: pc is %h, expected %h", $time, pc,
                   mipsPkg::pcReset + 32'(4 * k));
          errors++;
        end
      end
      repeat (budgets[t] - 4) @(posedge clk);
      @(negedge clk);

      checks++;
      assert (expAddr.size() == 0)
      else
      begin
        $display("%0d expected stores never happened", expAddr.size());
        errors++;
      end
      $display("test %0d %s: %s", t, testNames[t],
               (errors == testErrors) ? "passed" : "failed");
    end

    $display("%0d tests, %0d checks, %0d errors", budgets.size(), checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: flist.f
common/mipsPkg.sv
rtl/fetch/fetchStage.sv
rtl/decode/controlUnit.sv
rtl/decode/regFile.sv
rtl/decode/decodeStage.sv
rtl/execute/alu.sv
rtl/execute/forwardUnit.sv
rtl/execute/executeStage.sv
rtl/memWriteback.sv
rtl/mipsCore.sv
+incdir+dv
dv/mipsCoreTb.sv

// File: rtl/decode/controlUnit.sv
// ----------------------------------------------------------
// main decoder for the supported subset
// unknown opcodes and functs write nothing
// ----------------------------------------------------------
`timescale 1ns/1ps

module controlUnit (
  input  mipsPkg::instrWord_t instr,
  output logic                regDst,
  output logic                aluSrc,
  output logic                memToReg,
  output logic                regWrite,
  output logic                memWrite,
  output logic                memRead,
  output logic                branch,
  output logic                jump,
  output logic [3:0]          aluOp
);

  always_comb
  begin
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    memRead  = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    aluOp    = mipsPkg::aluAdd;
    case (instr.r.op)
      mipsPkg::opRType:
      begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (instr.r.funct)
          mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
          // includes the all-zero word
          default: regWrite = 1'b0;
        endcase
      end
      mipsPkg::opAddi:
      begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      mipsPkg::opAndi:
      begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        aluOp    = mipsPkg::aluAnd;
      end
      mipsPkg::opOri:
      begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        aluOp    = mipsPkg::aluOr;
      end
      mipsPkg::opLw:
      begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      mipsPkg::opSw:
      begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsPkg::opBeq:
      begin
        branch = 1'b1;
        aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opJ:   jump = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: rtl/decode/decodeStage.sv
// ----------------------------------------------------------
// decode, register read and the ID/EX register
// no load-use stall; code must keep a gap after lw
// ----------------------------------------------------------
`timescale 1ns/1ps

module decodeStage (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush,
  input  mipsPkg::instrWord_t idInstr,
  input  logic [31:0]         idPcPlus4,
  input  logic                wbRegWrite,
  input  logic [4:0]          wbDest,
  input  logic [31:0]         wbData,
  output logic                exRegDst,
  output logic                exAluSrc,
  output logic                exMemToReg,
  output logic                exRegWrite,
  output logic                exMemWrite,
  output logic                exMemRead,
  output logic                exBranch,
  output logic                exJump,
  output logic [3:0]          exAluOp,
  output logic [31:0]         exPcPlus4,
  output logic [31:0]         exRegA,
  output logic [31:0]         exRegB,
  output logic [31:0]         exImm,
  output mipsPkg::instrWord_t exInstr
);

  logic        regDst, aluSrc, memToReg, regWrite;
  logic        memWrite, memRead, branch, jump;
  logic [3:0]  aluOp;
  logic [31:0] regA, regB, imm;

  controlUnit i_controlUnit (
    .instr    (idInstr),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .memRead  (memRead),
    .branch   (branch),
    .jump     (jump),
    .aluOp    (aluOp)
  );

  regFile i_regFile (
    .clk    (clk),
    .rst    (rst),
    .raddrA (idInstr.r.rs),
    .raddrB (idInstr.r.rt),
    .waddr  (wbDest),
    .wen    (wbRegWrite),
    .wdata  (wbData),
    .rdataA (regA),
    .rdataB (regB)
  );

  assign imm = {{16{idInstr.i.imm[15]}}, idInstr.i.imm};

  // ----------------------------------------------------------
  // ID/EX register
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst || flush)
    begin
      {exRegDst, exAluSrc, exMemToReg, exRegWrite} <= '0;
      {exMemWrite, exMemRead, exBranch, exJump}    <= '0;
      exAluOp   <= '0;
      exPcPlus4 <= '0;
      exRegA    <= '0;
      exRegB    <= '0;
      exImm     <= '0;
      exInstr   <= '0;
    end
    else
    begin
      {exRegDst, exAluSrc, exMemToReg, exRegWrite} <= {regDst, aluSrc, memToReg, regWrite};
      {exMemWrite, exMemRead, exBranch, exJump}    <= {memWrite, memRead, branch, jump};
      exAluOp   <= aluOp;
      exPcPlus4 <= idPcPlus4;
      exRegA    <= regA;
      exRegB    <= regB;
      exImm     <= imm;
      exInstr   <= idInstr;
    end
  end

endmodule

// File: rtl/decode/regFile.sv
// ----------------------------------------------------------
// 32 x 32 register file, two reads and one write
// reads bypass the value being written this cycle
// register 0 reads zero and ignores writes
// ----------------------------------------------------------
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddrA,
  input  logic [4:0]  raddrB,
  input  logic [4:0]  waddr,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rdataA,
  output logic [31:0] rdataB
);

  logic [mipsPkg::dataWidth-1:0] regs [mipsPkg::regCount];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      regs <= '{default: '0};
    else if (wen && waddr != '0)
      regs[waddr] <= wdata;
  end

  // write-through
  assign rdataA = (raddrA == '0) ? '0 :
                  (wen && waddr == raddrA) ? wdata : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 :
                  (wen && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

// File: rtl/execute/alu.sv
// ----------------------------------------------------------
// 32-bit ALU with or, and, add, sub and signed slt
// no carry out; overflow only corrects slt
// ----------------------------------------------------------
`timescale 1ns/1ps

module alu (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [3:0]  aluOp,
  output logic [31:0] result,
  output logic        zero
);

  logic [mipsPkg::dataWidth-1:0] na, nb, sum;
  logic                          overflow;

  assign na  = aluOp[3] ? ~a : a;
  assign nb  = aluOp[2] ? ~b : b;
  assign sum = na + nb + {31'd0, aluOp[2]};

  // signed overflow of the shared adder
  assign overflow = (na[31] == nb[31]) && (sum[31] != na[31]);

  always_comb
  begin
    case (aluOp[1:0])
      2'b00:   result = na | nb;
      2'b01:   result = na & nb;
      2'b10:   result = sum;
      default: result = {31'd0, sum[31] ^ overflow};
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: rtl/execute/executeStage.sv
// ----------------------------------------------------------
// execute and the EX/MEM register
// branch and jump resolve here and act one cycle later in MEM
// memTaken clears its own register, so no delay slots
// ----------------------------------------------------------
`timescale 1ns/1ps

module executeStage (
  input  logic                clk,
  input  logic                rst,
  input  logic                exRegDst,
  input  logic                exAluSrc,
  input  logic                exMemToReg,
  input  logic                exRegWrite,
  input  logic                exMemWrite,
  input  logic                exMemRead,
  input  logic                exBranch,
  input  logic                exJump,
  input  logic [3:0]          exAluOp,
  input  logic [31:0]         exPcPlus4,
  input  logic [31:0]         exRegA,
  input  logic [31:0]         exRegB,
  input  logic [31:0]         exImm,
  input  mipsPkg::instrWord_t exInstr,
  input  logic [1:0]          fwdSelA,
  input  logic [1:0]          fwdSelB,
  input  logic [31:0]         wbData,
  output logic                memTaken,
  output logic [31:0]         memTarget,
  output logic [31:0]         memAluResult,
  output logic [31:0]         memStoreData,
  output logic                memWrite,
  output logic                memRead,
  output logic                memRegWrite,
  output logic                memMemToReg,
  output logic [4:0]          memDest
);

  logic [31:0] opA, opB, aluB, aluResult, target;
  logic [4:0]  dest;
  logic        zero, taken;

  // forwarded operands
  always_comb
  begin
    case (fwdSelA)
      mipsPkg::fwdMem: opA = memAluResult;
      mipsPkg::fwdWb:  opA = wbData;
      default:         opA = exRegA;
    endcase
    case (fwdSelB)
      mipsPkg::fwdMem: opB = memAluResult;
      mipsPkg::fwdWb:  opB = wbData;
      default:         opB = exRegB;
    endcase
  end

  assign aluB = exAluSrc ? exImm : opB;

  alu i_alu (
    .a      (opA),
    .b      (aluB),
    .aluOp  (exAluOp),
    .result (aluResult),
    .zero   (zero)
  );

  assign dest  = exRegDst ? exInstr.r.rd : exInstr.r.rt;
  assign taken = (exBranch && zero) || exJump;

  // jump keeps the upper PC bits
  assign target = exJump ? {exPcPlus4[31:28], exInstr.j.target, 2'b00}
                         : exPcPlus4 + {exImm[29:0], 2'b00};

  // ----------------------------------------------------------
  // EX/MEM register
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst || memTaken)
    begin
      {memTaken, memWrite, memRead, memRegWrite, memMemToReg} <= '0;
      memTarget    <= '0;
      memAluResult <= '0;
      memStoreData <= '0;
      memDest      <= '0;
    end
    else
    begin
      {memTaken, memWrite, memRead} <= {taken, exMemWrite, exMemRead};
      {memRegWrite, memMemToReg}    <= {exRegWrite, exMemToReg};
      memTarget    <= target;
      memAluResult <= aluResult;
      memStoreData <= opB;
      memDest      <= dest;
    end
  end

endmodule

// File: rtl/execute/forwardUnit.sv
// ----------------------------------------------------------
// operand source selection for execute
// MEM wins over WB; register 0 is never forwarded
// ----------------------------------------------------------
`timescale 1ns/1ps

module forwardUnit (
  input  logic [4:0] srcA,
  input  logic [4:0] srcB,
  input  logic [4:0] memDest,
  input  logic [4:0] wbDest,
  input  logic       memRegWrite,
  input  logic       wbRegWrite,
  output logic [1:0] fwdSelA,
  output logic [1:0] fwdSelB
);

  logic memHitA, memHitB, wbHitA, wbHitB;

  assign memHitA = memRegWrite && memDest != '0 && memDest == srcA;
  assign memHitB = memRegWrite && memDest != '0 && memDest == srcB;
  assign wbHitA  = wbRegWrite && wbDest != '0 && wbDest == srcA;
  assign wbHitB  = wbRegWrite && wbDest != '0 && wbDest == srcB;

  assign fwdSelA = memHitA ? mipsPkg::fwdMem : wbHitA ? mipsPkg::fwdWb : mipsPkg::fwdReg;
  assign fwdSelB = memHitB ? mipsPkg::fwdMem : wbHitB ? mipsPkg::fwdWb : mipsPkg::fwdReg;

endmodule

// File: rtl/fetch/fetchStage.sv
// ----------------------------------------------------------
// PC and IF/ID register
// the ROM must answer within the same cycle
// a taken branch in MEM loads the target and flushes IF/ID
// ----------------------------------------------------------
`timescale 1ns/1ps

module fetchStage (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         instrData,
  input  logic                memTaken,
  input  logic [31:0]         memTarget,
  output logic [31:0]         pc,
  output mipsPkg::instrWord_t idInstr,
  output logic [31:0]         idPcPlus4
);

  logic [31:0] pcPlus4;

  assign pcPlus4 = pc + 32'd4;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pc <= mipsPkg::pcReset;
    else if (memTaken)
      pc <= memTarget;
    else
      pc <= pcPlus4;
  end

  // a cleared word decodes as a bubble
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst || memTaken)
    begin
      idInstr   <= '0;
      idPcPlus4 <= '0;
    end
    else
    begin
      idInstr   <= instrData;
      idPcPlus4 <= pcPlus4;
    end
  end

endmodule

// File: rtl/memWriteback.sv
// ----------------------------------------------------------
// MEM/WB register and write-back select
// the data memory answers in the same cycle as the address
// ----------------------------------------------------------
`timescale 1ns/1ps

module memWriteback (
  input  logic        clk,
  input  logic        rst,
  input  logic        memRegWrite,
  input  logic        memMemToReg,
  input  logic [4:0]  memDest,
  input  logic [31:0] memAluResult,
  input  logic [31:0] memReadData,
  output logic        wbRegWrite,
  output logic [4:0]  wbDest,
  output logic [31:0] wbData
);

  logic        wbMemToReg;
  logic [31:0] wbAluResult, wbLoadData;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wbRegWrite  <= 1'b0;
      wbMemToReg  <= 1'b0;
      wbDest      <= '0;
      wbAluResult <= '0;
      wbLoadData  <= '0;
    end
    else
    begin
      wbRegWrite  <= memRegWrite;
      wbMemToReg  <= memMemToReg;
      wbDest      <= memDest;
      wbAluResult <= memAluResult;
      wbLoadData  <= memReadData;
    end
  end

  assign wbData = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

// File: rtl/mipsCore.sv
// ----------------------------------------------------------
// five-stage MIPS subset core
// both memories are external and combinational on read
// a taken beq or j squashes the three younger instructions
// ----------------------------------------------------------
`timescale 1ns/1ps

module mipsCore (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] instrData,
  output logic [31:0] pc,
  output logic [31:0] memAddr,
  output logic [31:0] memWriteData,
  output logic        memWrite,
  output logic        memRead,
  input  logic [31:0] memReadData
);

  // ----------------------------------------------------------
  // stage wires
  // ----------------------------------------------------------
  mipsPkg::instrWord_t idInstr, exInstr;
  logic [31:0]         idPcPlus4;

  logic        exRegDst, exAluSrc, exMemToReg, exRegWrite;
  logic        exMemWrite, exMemRead, exBranch, exJump;
  logic [3:0]  exAluOp;
  logic [31:0] exPcPlus4, exRegA, exRegB, exImm;
  logic [1:0]  fwdSelA, fwdSelB;

  logic        memTaken, memRegWrite, memMemToReg;
  logic [31:0] memTarget;
  logic [4:0]  memDest;

  logic        wbRegWrite;
  logic [4:0]  wbDest;
  logic [31:0] wbData;

  fetchStage i_fetchStage (
    .clk       (clk),
    .rst       (rst),
    .instrData (instrData),
    .memTaken  (memTaken),
    .memTarget (memTarget),
    .pc        (pc),
    .idInstr   (idInstr),
    .idPcPlus4 (idPcPlus4)
  );

  decodeStage i_decodeStage (
    .clk        (clk),
    .rst        (rst),
    .flush      (memTaken),
    .idInstr    (idInstr),
    .idPcPlus4  (idPcPlus4),
    .wbRegWrite (wbRegWrite),
    .wbDest     (wbDest),
    .wbData     (wbData),
    .exRegDst   (exRegDst),
    .exAluSrc   (exAluSrc),
    .exMemToReg (exMemToReg),
    .exRegWrite (exRegWrite),
    .exMemWrite (exMemWrite),
    .exMemRead  (exMemRead),
    .exBranch   (exBranch),
    .exJump     (exJump),
    .exAluOp    (exAluOp),
    .exPcPlus4  (exPcPlus4),
    .exRegA     (exRegA),
    .exRegB     (exRegB),
    .exImm      (exImm),
    .exInstr    (exInstr)
  );

  forwardUnit i_forwardUnit (
    .srcA        (exInstr.r.rs),
    .srcB        (exInstr.r.rt),
    .memDest     (memDest),
    .wbDest      (wbDest),
    .memRegWrite (memRegWrite),
    .wbRegWrite  (wbRegWrite),
    .fwdSelA     (fwdSelA),
    .fwdSelB     (fwdSelB)
  );

  executeStage i_executeStage (
    .clk          (clk),
    .rst          (rst),
    .exRegDst     (exRegDst),
    .exAluSrc     (exAluSrc),
    .exMemToReg   (exMemToReg),
    .exRegWrite   (exRegWrite),
    .exMemWrite   (exMemWrite),
    .exMemRead    (exMemRead),
    .exBranch     (exBranch),
    .exJump       (exJump),
    .exAluOp      (exAluOp),
    .exPcPlus4    (exPcPlus4),
    .exRegA       (exRegA),
    .exRegB       (exRegB),
    .exImm        (exImm),
    .exInstr      (exInstr),
    .fwdSelA      (fwdSelA),
    .fwdSelB      (fwdSelB),
    .wbData       (wbData),
    .memTaken     (memTaken),
    .memTarget    (memTarget),
    .memAluResult (memAddr),
    .memStoreData (memWriteData),
    .memWrite     (memWrite),
    .memRead      (memRead),
    .memRegWrite  (memRegWrite),
    .memMemToReg  (memMemToReg),
    .memDest      (memDest)
  );

  memWriteback i_memWriteback (
    .clk          (clk),
    .rst          (rst),
    .memRegWrite  (memRegWrite),
    .memMemToReg  (memMemToReg),
    .memDest      (memDest),
    .memAluResult (memAddr),
    .memReadData  (memReadData),
    .wbRegWrite   (wbRegWrite),
    .wbDest       (wbDest),
    .wbData       (wbData)
  );

endmodule
